// ==== flist.f ====
+incdir+include
hw/sample_pkg.sv
hw/weight_pkg.sv
hw/weight_bank.sv
hw/channel_weighter.sv
hw/channel_combiner.sv
hw/beamform_top.sv
testbench/beamform_assertions.sv
testbench/beamform_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the beamformer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module beamform_tb -f flist.f --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vbeamform_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== testbench/beamform_tb.sv ====
// beamformer testbench checking random beats against a reference model of weighting and commits
`include "beamform_defines.svh"

module beamform_tb;

    import sample_pkg::*;

    // test lengths in cycles
    localparam int reset_cycles  = 16;
    localparam int idle_cycles   = 20;
    localparam int unit_beats    = 40;
    localparam int complex_beats = 64;
    localparam int partial_beats = 64;
    localparam int commit_beats  = 24;
    // weight load, commit and pipeline drain around each test
    localparam int setup_cycles  = 12;
    localparam int cycle_limit   = reset_cycles + idle_cycles + unit_beats + complex_beats
                                 + partial_beats + commit_beats + 5 * setup_cycles + 200;

    logic                               clock;
    logic                               resetn;
    logic [`BF_CHANNELS-1:0]            in_valid;
    logic                               in_last;
    sample_word_u                       in_real [`BF_CHANNELS];
    sample_word_u                       in_imag [`BF_CHANNELS];
    logic signed [`BF_WEIGHT_WIDTH-1:0] weight_real [`BF_CHANNELS];
    logic signed [`BF_WEIGHT_WIDTH-1:0] weight_imag [`BF_CHANNELS];
    logic                               weight_load;
    logic                               out_valid;
    logic                               out_last;
    sample_word_u                       out_real;
    sample_word_u                       out_imag;

    // weights put on the bus by the next driven cycle
    logic signed [`BF_WEIGHT_WIDTH-1:0] next_wr [`BF_CHANNELS];
    logic signed [`BF_WEIGHT_WIDTH-1:0] next_wi [`BF_CHANNELS];

    // model copy of the weight bank
    logic [`BF_CHANNELS-1:0][`BF_WEIGHT_WIDTH-1:0] model_active_real;
    logic [`BF_CHANNELS-1:0][`BF_WEIGHT_WIDTH-1:0] model_active_imag;
    logic [`BF_CHANNELS-1:0][`BF_WEIGHT_WIDTH-1:0] model_shadow_real;
    logic [`BF_CHANNELS-1:0][`BF_WEIGHT_WIDTH-1:0] model_shadow_imag;
    logic                                          model_pending;

    // expected beats in arrival order
    logic [`BF_WORD_WIDTH-1:0] exp_real_q [$];
    logic [`BF_WORD_WIDTH-1:0] exp_imag_q [$];
    logic                      exp_last_q [$];
    int                        exp_due_q [$];

    int    seed = 32'hd1ef_ee30;
    int    cycle = 0;
    int    errors = 0;
    int    test_start_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    string test_name = "reset";

    beamform_top i_dut (
        .clock       (clock),
        .resetn      (resetn),
        .in_valid    (in_valid),
        .in_last     (in_last),
        .in_real     (in_real),
        .in_imag     (in_imag),
        .weight_real (weight_real),
        .weight_imag (weight_imag),
        .weight_load (weight_load),
        .out_valid   (out_valid),
        .out_last    (out_last),
        .out_real    (out_real),
        .out_imag    (out_imag)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // weighted sum of one beat with Q1.7 multiply then divide by four, both truncated
    function automatic logic [2*`BF_WORD_WIDTH-1:0] reference_beat(
        input logic [`BF_CHANNELS-1:0]                     valid,
        input logic [`BF_CHANNELS-1:0][`BF_WORD_WIDTH-1:0] xr_words,
        input logic [`BF_CHANNELS-1:0][`BF_WORD_WIDTH-1:0] xi_words,
        input logic [`BF_CHANNELS-1:0][`BF_WEIGHT_WIDTH-1:0] wr_set,
        input logic [`BF_CHANNELS-1:0][`BF_WEIGHT_WIDTH-1:0] wi_set
    );
        logic [`BF_WORD_WIDTH-1:0] res_r;
        logic [`BF_WORD_WIDTH-1:0] res_i;
        logic [15:0]               part_r;
        logic [15:0]               part_i;
        int xr;
        int xi;
        int wr;
        int wi;
        int prod_r;
        int prod_i;
        int sum_r;
        int sum_i;
        for (int s = 0; s < `BF_SAMPLES; s++) begin
            sum_r = 0;
            sum_i = 0;
            for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
                if (valid[ch]) begin
                    xr = $signed(xr_words[ch][s*16 +: 16]);
                    xi = $signed(xi_words[ch][s*16 +: 16]);
                    wr = $signed(wr_set[ch]);
                    wi = $signed(wi_set[ch]);
                    prod_r = (wr * xr - wi * xi) >>> 7;
                    prod_i = (wr * xi + wi * xr) >>> 7;
                    // each weighted sample wraps to 16 bits before the sum
                    part_r = prod_r[15:0];
                    part_i = prod_i[15:0];
                    sum_r = sum_r + $signed(part_r);
                    sum_i = sum_i + $signed(part_i);
                end
            end
            sum_r = sum_r >>> 2;
            sum_i = sum_i >>> 2;
            res_r[s*16 +: 16] = sum_r[15:0];
            res_i[s*16 +: 16] = sum_i[15:0];
        end
        return {res_i, res_r};
    endfunction

    function automatic logic [`BF_WORD_WIDTH-1:0] random_word();
        logic [`BF_WORD_WIDTH-1:0] w;
        for (int k = 0; k < 4; k++) begin
            w[k*32 +: 32] = $random(seed);
        end
        return w;
    endfunction

    task automatic check_value(input string field, input logic [`BF_WORD_WIDTH-1:0] expected,
                               input logic [`BF_WORD_WIDTH-1:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s, %s: expected %h, actual %h",
                     test_name, field, expected, actual);
            errors++;
        end
    endtask

    // one cycle of stimulus with fresh random samples on every channel
    task automatic drive_cycle(input logic [`BF_CHANNELS-1:0] mask, input logic last,
                               input logic load);
        @(posedge clock);
        in_valid    <= mask;
        in_last     <= last;
        weight_load <= load;
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            in_real[ch]     <= random_word();
            in_imag[ch]     <= random_word();
            weight_real[ch] <= next_wr[ch];
            weight_imag[ch] <= next_wi[ch];
        end
    endtask

    // load strobe then one idle cycle so the set commits before the next beat
    task automatic load_weights();
        drive_cycle('0, 1'b0, 1'b1);
        drive_cycle('0, 1'b0, 1'b0);
    endtask

    task automatic random_weights();
        int rnd;
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            rnd = $random(seed);
            next_wr[ch] = rnd[7:0];
            next_wi[ch] = rnd[15:8];
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_start_errors = errors;
    endtask

    // return to idle, wait for the pipeline to empty and report
    // the queue is read between edges, after the model and the compare have run
    task automatic end_test();
        drive_cycle('0, 1'b0, 1'b0);
        @(negedge clock);
        while (exp_due_q.size() != 0) begin
            @(negedge clock);
        end
        // two more idle cycles catch stray output beats
        repeat (2) @(negedge clock);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - test_start_errors);
        end
    endtask

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // model of the bank sampling the inputs the DUT sees on this edge
    always @(posedge clock) begin
        logic [`BF_CHANNELS-1:0][`BF_WORD_WIDTH-1:0] seen_real;
        logic [`BF_CHANNELS-1:0][`BF_WORD_WIDTH-1:0] seen_imag;
        logic [2*`BF_WORD_WIDTH-1:0]                 expected;
        logic                                        commit;
        if (!resetn) begin
            model_active_real <= '0;
            model_active_imag <= '0;
            model_shadow_real <= '0;
            model_shadow_imag <= '0;
            model_pending     <= 1'b0;
        end else begin
            for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
                seen_real[ch] = in_real[ch].word;
                seen_imag[ch] = in_imag[ch].word;
            end
            // the beat on this edge uses the weights active before it
            if (|in_valid) begin
                expected = reference_beat(in_valid, seen_real, seen_imag,
                                          model_active_real, model_active_imag);
                exp_real_q.push_back(expected[`BF_WORD_WIDTH-1:0]);
                exp_imag_q.push_back(expected[2*`BF_WORD_WIDTH-1:`BF_WORD_WIDTH]);
                exp_last_q.push_back(in_last);
                exp_due_q.push_back(cycle + 2);
            end
            commit = model_pending && (!(|in_valid) || in_last);
            if (commit) begin
                model_active_real <= model_shadow_real;
                model_active_imag <= model_shadow_imag;
            end
            if (weight_load) begin
                model_pending <= 1'b1;
                for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
                    model_shadow_real[ch] <= weight_real[ch];
                    model_shadow_imag[ch] <= weight_imag[ch];
                end
            end else if (commit) begin
                model_pending <= 1'b0;
            end
        end
    end

    // compare outputs against the expected queue
    always @(posedge clock) begin
        if (resetn) begin
            if (out_valid) begin
                if (exp_due_q.size() == 0) begin
                    $display("Unexpected output beat in %s at cycle %0d", test_name, cycle);
                    errors++;
                end else begin
                    if (exp_due_q[0] != cycle) begin
                        $display("Output beat in %s at cycle %0d, expected at cycle %0d",
                                 test_name, cycle, exp_due_q[0]);
                        errors++;
                    end
                    check_value("real", exp_real_q.pop_front(), out_real.word);
                    check_value("imag", exp_imag_q.pop_front(), out_imag.word);
                    check_value("last", exp_last_q.pop_front(), out_last);
                    void'(exp_due_q.pop_front());
                end
            end else begin
                if (exp_due_q.size() != 0 && exp_due_q[0] <= cycle) begin
                    $display("No output beat in %s for the beat due at cycle %0d",
                             test_name, exp_due_q[0]);
                    errors++;
                    void'(exp_real_q.pop_front());
                    void'(exp_imag_q.pop_front());
                    void'(exp_last_q.pop_front());
                    void'(exp_due_q.pop_front());
                end
                // idle outputs stay at zero
                check_value("idle real", '0, out_real.word);
                check_value("idle imag", '0, out_imag.word);
                check_value("idle last", '0, out_last);
            end
        end
    end

    always @(posedge clock) begin
        if (cycle >= cycle_limit) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        int                      rnd;
        logic [`BF_CHANNELS-1:0] mask;
        int                      total_errors;
        resetn      = 1'b0;
        in_valid    = '0;
        in_last     = 1'b0;
        weight_load = 1'b0;
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            in_real[ch]     = '0;
            in_imag[ch]     = '0;
            weight_real[ch] = '0;
            weight_imag[ch] = '0;
            next_wr[ch]     = '0;
            next_wi[ch]     = '0;
        end
        repeat (reset_cycles) @(posedge clock);
        resetn <= 1'b1;

        begin_test("reset");
        repeat (idle_cycles) drive_cycle('0, 1'b0, 1'b0);
        end_test();

        // real 127 is just under one, so outputs lose a little to truncation
        begin_test("unit weights");
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            next_wr[ch] = 8'sd127;
            next_wi[ch] = '0;
        end
        load_weights();
        for (int i = 0; i < unit_beats; i++) begin
            drive_cycle('1, i % 8 == 7, 1'b0);
        end
        end_test();

        begin_test("complex weights");
        random_weights();
        load_weights();
        for (int i = 0; i < complex_beats; i++) begin
            drive_cycle('1, i % 8 == 7, 1'b0);
        end
        end_test();

        // single channels first, then random masks with some empty cycles
        begin_test("partial channels");
        random_weights();
        load_weights();
        for (int i = 0; i < partial_beats; i++) begin
            rnd = $random(seed);
            mask = (i < 4) ? 4'b0001 << i : rnd[3:0];
            drive_cycle(mask, i % 8 == 7, 1'b0);
        end
        end_test();

        // three back-to-back frames of six beats
        // B loads mid frame 1, C loads on its last beat and waits for the end of frame 2
        begin_test("weight commit");
        random_weights();
        load_weights();
        for (int i = 0; i < 18; i++) begin
            if (i == 2 || i == 5) begin
                random_weights();
            end
            drive_cycle('1, i % 6 == 5, i == 2 || i == 5);
        end
        end_test();

        total_errors = errors + i_dut.i_checks.failures;
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== testbench/beamform_assertions.sv ====
// bound protocol checks on the beamformer, output latency, last framing and weight commits
`include "beamform_defines.svh"

module beamform_assertions (
    input logic                                       clock,
    input logic                                       resetn,
    input logic [`BF_CHANNELS-1:0]                    in_valid,
    input logic                                       in_last,
    input logic                                       out_valid,
    input logic                                       out_last,
    // every active weight side by side, real parts first
    input logic [2*`BF_CHANNELS*`BF_WEIGHT_WIDTH-1:0] active_flat
);

    // failed assertions, read by the testbench at the end of the run
    int failures = 0;

    logic beat;
    logic boundary;

    assign beat     = |in_valid;
    assign boundary = !beat || in_last;

    // a beat comes out two cycles later, and nothing else comes out
    beat_to_output: assert property (@(posedge clock) disable iff (!resetn)
        beat |-> ##2 out_valid)
        else begin
            failures++;
            $error("beat without an output two cycles later");
        end

    output_from_beat: assert property (@(posedge clock) disable iff (!resetn)
        out_valid |-> $past(beat, 2))
        else begin
            failures++;
            $error("output without a beat two cycles earlier");
        end

    last_needs_valid: assert property (@(posedge clock) disable iff (!resetn)
        out_last |-> out_valid)
        else begin
            failures++;
            $error("out_last high while out_valid is low");
        end

    // new weights only after an idle cycle or the last beat of a frame
    commit_on_boundary: assert property (@(posedge clock) disable iff (!resetn)
        $changed(active_flat) |-> $past(boundary))
        else begin
            failures++;
            $error("active weights changed inside a frame");
        end

endmodule

bind beamform_top beamform_assertions i_checks (
    .clock       (clock),
    .resetn      (resetn),
    .in_valid    (in_valid),
    .in_last     (in_last),
    .out_valid   (out_valid),
    .out_last    (out_last),
    .active_flat ({active_real[3], active_real[2], active_real[1], active_real[0],
                   active_imag[3], active_imag[2], active_imag[1], active_imag[0]})
);

// ==== hw/beamform_top.sv ====
// four-channel complex beamformer, weight bank plus two-stage weight-and-sum datapath
`include "beamform_defines.svh"

module beamform_top (
    input  logic                               clock,
    input  logic                               resetn,
    // input beat, one valid bit per channel
    input  logic [`BF_CHANNELS-1:0]            in_valid,
    input  logic                               in_last,
    input  sample_pkg::sample_word_u           in_real [`BF_CHANNELS],
    input  sample_pkg::sample_word_u           in_imag [`BF_CHANNELS],
    // weight update, Q1.7 per channel
    input  logic signed [`BF_WEIGHT_WIDTH-1:0] weight_real [`BF_CHANNELS],
    input  logic signed [`BF_WEIGHT_WIDTH-1:0] weight_imag [`BF_CHANNELS],
    input  logic                               weight_load,
    // combined beam, two cycles after the input beat
    output logic                               out_valid,
    output logic                               out_last,
    output sample_pkg::sample_word_u           out_real,
    output sample_pkg::sample_word_u           out_imag
);

    // bank to weighter
    logic signed [`BF_WEIGHT_WIDTH-1:0] active_real [`BF_CHANNELS];
    logic signed [`BF_WEIGHT_WIDTH-1:0] active_imag [`BF_CHANNELS];

    // weighter back to the bank for the commit rule
    logic beat_present;

    // weighter to combiner
    logic [`BF_CHANNELS-1:0]  weighted_valid;
    logic                     weighted_last;
    sample_pkg::sample_word_u weighted_real [`BF_CHANNELS];
    sample_pkg::sample_word_u weighted_imag [`BF_CHANNELS];

    weight_bank i_weight_bank (
        .clock        (clock),
        .resetn       (resetn),
        .weight_load  (weight_load),
        .weight_real  (weight_real),
        .weight_imag  (weight_imag),
        .beat_present (beat_present),
        .in_last      (in_last),
        .active_real  (active_real),
        .active_imag  (active_imag)
    );

    // stage 1, multiply
    channel_weighter i_channel_weighter (
        .clock          (clock),
        .resetn         (resetn),
        .in_valid       (in_valid),
        .in_last        (in_last),
        .in_real        (in_real),
        .in_imag        (in_imag),
        .active_real    (active_real),
        .active_imag    (active_imag),
        .beat_present   (beat_present),
        .weighted_valid (weighted_valid),
        .weighted_last  (weighted_last),
        .weighted_real  (weighted_real),
        .weighted_imag  (weighted_imag)
    );

    // stage 2, sum and scale
    channel_combiner i_channel_combiner (
        .clock          (clock),
        .resetn         (resetn),
        .weighted_valid (weighted_valid),
        .weighted_last  (weighted_last),
        .weighted_real  (weighted_real),
        .weighted_imag  (weighted_imag),
        .out_valid      (out_valid),
        .out_last       (out_last),
        .out_real       (out_real),
        .out_imag       (out_imag)
    );

endmodule

// ==== hw/channel_combiner.sv ====
// four-channel sample-wise sum with divide by channel count, output register
`include "beamform_defines.svh"

module channel_combiner (
    input  logic                     clock,
    input  logic                     resetn,
    // weighted channels from the multiply stage
    input  logic [`BF_CHANNELS-1:0]  weighted_valid,
    input  logic                     weighted_last,
    input  sample_pkg::sample_word_u weighted_real [`BF_CHANNELS],
    input  sample_pkg::sample_word_u weighted_imag [`BF_CHANNELS],
    // combined beam
    output logic                     out_valid,
    output logic                     out_last,
    output sample_pkg::sample_word_u out_real,
    output sample_pkg::sample_word_u out_imag
);

    import sample_pkg::*;

    // room for four full-scale samples without wrap
    localparam int acc_width = `BF_SAMPLE_WIDTH + $clog2(`BF_CHANNELS);

    // widened per-sample sums
    logic signed [acc_width-1:0] sum_real [`BF_SAMPLES];
    logic signed [acc_width-1:0] sum_imag [`BF_SAMPLES];

    // scaled result before the output register
    sample_word_u next_real;
    sample_word_u next_imag;

    // any weighted channel makes a beat
    logic beat;

    assign beat = |weighted_valid;

    always_comb begin
        for (int s = 0; s < `BF_SAMPLES; s++) begin
            sum_real[s] = '0;
            sum_imag[s] = '0;
            // invalid channels arrive as zero, so all four are summed
            for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
                sum_real[s] = sum_real[s] + $signed(weighted_real[ch].sample[s]);
                sum_imag[s] = sum_imag[s] + $signed(weighted_imag[ch].sample[s]);
            end
            // arithmetic shift then truncate to sample width
            // same as taking the bits just above the shift
            next_real.sample[s] = sum_real[s][`BF_SUM_SHIFT +: `BF_SAMPLE_WIDTH];
            next_imag.sample[s] = sum_imag[s][`BF_SUM_SHIFT +: `BF_SAMPLE_WIDTH];
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            out_real  <= '0;
            out_imag  <= '0;
        end else begin
            out_valid <= beat;
            out_last  <= weighted_last;
            // words held at zero between beats
            out_real  <= beat ? next_real : '0;
            out_imag  <= beat ? next_imag : '0;
        end
    end

endmodule

// ==== hw/channel_weighter.sv ====
// per-channel complex weight multiply, one register stage
`include "beamform_defines.svh"

module channel_weighter (
    input  logic                               clock,
    input  logic                               resetn,
    // one valid bit per channel
    input  logic [`BF_CHANNELS-1:0]            in_valid,
    input  logic                               in_last,
    input  sample_pkg::sample_word_u           in_real [`BF_CHANNELS],
    input  sample_pkg::sample_word_u           in_imag [`BF_CHANNELS],
    // weights from the bank, stable for the whole beat
    input  logic signed [`BF_WEIGHT_WIDTH-1:0] active_real [`BF_CHANNELS],
    input  logic signed [`BF_WEIGHT_WIDTH-1:0] active_imag [`BF_CHANNELS],
    // any channel valid, the bank uses it to find frame boundaries
    output logic                               beat_present,
    // stage outputs toward the combiner
    output logic [`BF_CHANNELS-1:0]            weighted_valid,
    output logic                               weighted_last,
    output sample_pkg::sample_word_u           weighted_real [`BF_CHANNELS],
    output sample_pkg::sample_word_u           weighted_imag [`BF_CHANNELS]
);

    import weight_pkg::*;

    // a beat exists when any channel is valid
    assign beat_present = |in_valid;

    // control stage
    always_ff @(posedge clock) begin
        if (!resetn) begin
            weighted_valid <= '0;
            weighted_last  <= 1'b0;
        end else begin
            weighted_valid <= in_valid;
            // last only means something with a beat attached
            weighted_last  <= in_last && beat_present;
        end
    end

    // payload stage
    // each channel and sample gets its own pair of multipliers
    always_ff @(posedge clock) begin
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            for (int s = 0; s < `BF_SAMPLES; s++) begin
                if (in_valid[ch]) begin
                    weighted_real[ch].sample[s] <= weight_real_part(
                        in_real[ch].sample[s],
                        in_imag[ch].sample[s],
                        active_real[ch],
                        active_imag[ch]
                    );
                    weighted_imag[ch].sample[s] <= weight_imag_part(
                        in_real[ch].sample[s],
                        in_imag[ch].sample[s],
                        active_real[ch],
                        active_imag[ch]
                    );
                end else begin
                    // idle channel adds nothing to the sum downstream
                    weighted_real[ch].sample[s] <= '0;
                    weighted_imag[ch].sample[s] <= '0;
                end
            end
        end
    end

endmodule

// ==== hw/weight_bank.sv ====
// shadow and active weight registers, new weights take effect only between frames
`include "beamform_defines.svh"

module weight_bank (
    input  logic                               clock,
    input  logic                               resetn,
    // one-cycle strobe, captures the weight inputs into the shadow set
    input  logic                               weight_load,
    input  logic signed [`BF_WEIGHT_WIDTH-1:0] weight_real [`BF_CHANNELS],
    input  logic signed [`BF_WEIGHT_WIDTH-1:0] weight_imag [`BF_CHANNELS],
    // a beat is on the input this cycle
    input  logic                               beat_present,
    input  logic                               in_last,
    // weights applied by the weighter
    output logic signed [`BF_WEIGHT_WIDTH-1:0] active_real [`BF_CHANNELS],
    output logic signed [`BF_WEIGHT_WIDTH-1:0] active_imag [`BF_CHANNELS]
);

    // loaded but not yet applied
    logic signed [`BF_WEIGHT_WIDTH-1:0] shadow_real [`BF_CHANNELS];
    logic signed [`BF_WEIGHT_WIDTH-1:0] shadow_imag [`BF_CHANNELS];

    // shadow holds a set the active bank has not seen yet
    logic pending;

    // frame boundary
    // either the line is idle or the current beat closes its frame
    logic frame_boundary;

    // commit on the first boundary with a pending set
    logic commit;

    assign frame_boundary = !beat_present || in_last;
    assign commit         = pending && frame_boundary;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            pending <= 1'b0;
            for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
                shadow_real[ch] <= '0;
                shadow_imag[ch] <= '0;
                active_real[ch] <= '0;
                active_imag[ch] <= '0;
            end
        end else begin
            // active takes the shadow as it was before this edge
            // the beat on this edge still sees the old active set
            if (commit) begin
                for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
                    active_real[ch] <= shadow_real[ch];
                    active_imag[ch] <= shadow_imag[ch];
                end
            end

            // a load on the commit edge stays pending for the next boundary
            if (weight_load) begin
                pending <= 1'b1;
                for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
                    shadow_real[ch] <= weight_real[ch];
                    shadow_imag[ch] <= weight_imag[ch];
                end
            end else if (commit) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/weight_pkg.sv ====
// Q1.7 complex weighting arithmetic for one sample
`include "beamform_defines.svh"

package weight_pkg;

    // drop the weight fraction bits and keep the low sample bits
    // plain truncation, no rounding and no saturation
    function automatic logic signed [`BF_SAMPLE_WIDTH-1:0] scale_product(
        input logic signed [`BF_SAMPLE_WIDTH+`BF_WEIGHT_WIDTH:0] acc
    );
        logic signed [`BF_SAMPLE_WIDTH+`BF_WEIGHT_WIDTH:0] shifted;
        shifted = acc >>> `BF_FRAC_SHIFT;
        return shifted[`BF_SAMPLE_WIDTH-1:0];
    endfunction

    // real part, wr*xr - wi*xi
    function automatic logic signed [`BF_SAMPLE_WIDTH-1:0] weight_real_part(
        input logic signed [`BF_SAMPLE_WIDTH-1:0] xr,
        input logic signed [`BF_SAMPLE_WIDTH-1:0] xi,
        input logic signed [`BF_WEIGHT_WIDTH-1:0] wr,
        input logic signed [`BF_WEIGHT_WIDTH-1:0] wi
    );
        logic signed [`BF_SAMPLE_WIDTH+`BF_WEIGHT_WIDTH:0] acc;
        // one extra bit holds the difference of two full products
        acc = wr * xr - wi * xi;
        return scale_product(acc);
    endfunction

    // imaginary part, wr*xi + wi*xr
    function automatic logic signed [`BF_SAMPLE_WIDTH-1:0] weight_imag_part(
        input logic signed [`BF_SAMPLE_WIDTH-1:0] xr,
        input logic signed [`BF_SAMPLE_WIDTH-1:0] xi,
        input logic signed [`BF_WEIGHT_WIDTH-1:0] wr,
        input logic signed [`BF_WEIGHT_WIDTH-1:0] wi
    );
        logic signed [`BF_SAMPLE_WIDTH+`BF_WEIGHT_WIDTH:0] acc;
        acc = wr * xi + wi * xr;
        return scale_product(acc);
    endfunction

endpackage

// ==== hw/sample_pkg.sv ====
// sample word type, one bus word seen flat or as packed signed samples
`include "beamform_defines.svh"

package sample_pkg;

    // one 128-bit bus word
    // sample 0 lives in the low 16 bits, sample 7 in the top bits
    // the sample view is signed as a whole, so single samples
    // need $signed() where sign matters
    typedef union packed {
        // flat view as it arrives on the bus
        logic [`BF_WORD_WIDTH-1:0] word;
        // per-sample view
        logic signed [`BF_SAMPLES-1:0][`BF_SAMPLE_WIDTH-1:0] sample;
    } sample_word_u;

endpackage

// ==== include/beamform_defines.svh ====
// beamformer sizing constants shared by the datapath and its testbench
`ifndef BEAMFORM_DEFINES_SVH
`define BEAMFORM_DEFINES_SVH

// antenna channels combined into one beam
`define BF_CHANNELS 4

// one signed sample in a bus word
`define BF_SAMPLE_WIDTH 16

// samples carried per 128-bit word
`define BF_SAMPLES 8

// real or imaginary bus word
`define BF_WORD_WIDTH 128

// signed weight, Q1.7
`define BF_WEIGHT_WIDTH 8

// fraction bits dropped after the weight multiply
`define BF_FRAC_SHIFT 7

// divide by the channel count after summing
`define BF_SUM_SHIFT 2

`endif
